/* source/cpuPackage.sv */
package cpuPackage;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  regSel_t;
   typedef logic [4:0]  opcode_t;
   typedef logic [2:0]  aluOp_t;

   // Opcodes of the supported subset
   localparam opcode_t OP_HALT    = 5'b00000;
   localparam opcode_t OP_NOP     = 5'b00001;
   localparam opcode_t OP_ADDI    = 5'b01000;
   localparam opcode_t OP_SUBI    = 5'b01001;
   localparam opcode_t OP_XORI    = 5'b01010;
   localparam opcode_t OP_BEQZ    = 5'b01100;
   localparam opcode_t OP_BNEZ    = 5'b01101;
   localparam opcode_t OP_J       = 5'b00100;
   localparam opcode_t OP_JAL     = 5'b00110;
   localparam opcode_t OP_ST      = 5'b10000;
   localparam opcode_t OP_LD      = 5'b10001;
   localparam opcode_t OP_LBI     = 5'b11000;
   localparam opcode_t OP_RFORMAT = 5'b11011;

   localparam aluOp_t ALU_ADD   = 3'd0;
   localparam aluOp_t ALU_SUB   = 3'd1;
   localparam aluOp_t ALU_XOR   = 3'd2;
   localparam aluOp_t ALU_AND   = 3'd3;
   localparam aluOp_t ALU_PASSB = 3'd4;

   // Destination field select
   localparam logic [1:0] DST_RD   = 2'd0;
   localparam logic [1:0] DST_IMM  = 2'd1;
   localparam logic [1:0] DST_RS   = 2'd2;
   localparam logic [1:0] DST_LINK = 2'd3;

   // Immediate width and extension
   localparam logic [1:0] IMM_S5  = 2'd0;
   localparam logic [1:0] IMM_Z5  = 2'd1;
   localparam logic [1:0] IMM_S8  = 2'd2;
   localparam logic [1:0] IMM_S11 = 2'd3;

   localparam int IMEM_DEPTH = 256;
   localparam int DMEM_DEPTH = 256;
   localparam regSel_t LINK_REG = 3'd7;

   typedef struct packed {
      logic       halt;
      logic       jump;
      logic       jumpImm;
      logic       link;
      logic       branchZero;
      logic       branchNonZero;
      logic       memRead;
      logic       memWrite;
      logic       memToReg;
      logic       aluSrc;
      logic       regWrite;
      logic [1:0] regDst;
      logic [1:0] immSel;
      aluOp_t     aluOp;
   } controlSignals_t;

   typedef struct packed {
      logic    valid;
      regSel_t sel;
      word_t   data;
   } commit_t;

   typedef struct packed {
      logic       enable;
      logic [7:0] address;
      word_t      data;
   } programWrite_t;

endpackage

/* source/fetch.sv */
`timescale 1ns/1ps

module fetch (
   input  logic                        clk,
   input  logic                        reset,
   input  cpuPackage::programWrite_t   programWrite,
   input  cpuPackage::controlSignals_t controls,
   input  logic                        illegal,
   input  logic                        branchTaken,
   input  cpuPackage::word_t           jumpTarget,
   input  cpuPackage::word_t           immediate,
   output cpuPackage::word_t           instruction,
   output cpuPackage::word_t           nextPc,
   output logic                        halted,
   output logic                        err
);
   import cpuPackage::*;

   word_t instrMem [IMEM_DEPTH];
   word_t pc;
   word_t pcTarget;

   // Byte addressed, so drop bit 0
   assign instruction = instrMem[pc[8:1]];
   assign nextPc = pc + 16'd2;

   always_comb begin
      if (controls.jump) begin
         pcTarget = jumpTarget;
      end else if (branchTaken || controls.jumpImm) begin
         pcTarget = nextPc + immediate;
      end else begin
         pcTarget = nextPc;
      end
   end

   always_ff @(posedge clk) begin
      if (programWrite.enable) begin
         instrMem[programWrite.address] <= programWrite.data;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
         halted <= 1'b0;
         err <= 1'b0;
      end else if (!halted) begin
         // Stop on halt or illegal opcode, PC stays on it
         if (controls.halt || illegal) begin
            halted <= 1'b1;
            err <= illegal;
         end else begin
            pc <= pcTarget;
         end
      end
   end

endmodule

/* source/control.sv */
`timescale 1ns/1ps

module control (
   input  cpuPackage::word_t           instruction,
   output cpuPackage::controlSignals_t controls,
   output logic                        illegal
);
   import cpuPackage::*;

   opcode_t opcode;
   logic [1:0] extension;

   assign opcode = instruction[15:11];
   assign extension = instruction[1:0];

   always_comb begin
      // Everything off unless the opcode turns it on
      controls = '0;
      illegal = 1'b0;
      case (opcode)
         OP_HALT: begin
            controls.halt = 1'b1;
         end
         OP_NOP: begin
         end
         OP_ADDI, OP_SUBI, OP_XORI: begin
            controls.aluSrc = 1'b1;
            controls.regWrite = 1'b1;
            controls.regDst = DST_IMM;
            controls.immSel = (opcode == OP_XORI) ? IMM_Z5 : IMM_S5;
            controls.aluOp = (opcode == OP_ADDI) ? ALU_ADD :
                             (opcode == OP_SUBI) ? ALU_SUB : ALU_XOR;
         end
         OP_LBI: begin
            controls.aluSrc = 1'b1;
            controls.regWrite = 1'b1;
            controls.regDst = DST_RS;
            controls.immSel = IMM_S8;
            controls.aluOp = ALU_PASSB;
         end
         OP_LD: begin
            controls.memRead = 1'b1;
            controls.memToReg = 1'b1;
            controls.aluSrc = 1'b1;
            controls.regWrite = 1'b1;
            controls.regDst = DST_IMM;
            controls.immSel = IMM_S5;
            controls.aluOp = ALU_ADD;
         end
         OP_ST: begin
            controls.memWrite = 1'b1;
            controls.aluSrc = 1'b1;
            controls.immSel = IMM_S5;
            controls.aluOp = ALU_ADD;
         end
         OP_BEQZ, OP_BNEZ: begin
            controls.branchZero = (opcode == OP_BEQZ);
            controls.branchNonZero = (opcode == OP_BNEZ);
            controls.immSel = IMM_S8;
         end
         OP_J, OP_JAL: begin
            controls.jumpImm = 1'b1;
            controls.immSel = IMM_S11;
            // JAL saves the return address in r7
            controls.link = (opcode == OP_JAL);
            controls.regWrite = (opcode == OP_JAL);
            controls.regDst = DST_LINK;
         end
         OP_RFORMAT: begin
            controls.regWrite = 1'b1;
            controls.regDst = DST_RD;
            case (extension)
               2'b00: controls.aluOp = ALU_ADD;
               2'b01: controls.aluOp = ALU_SUB;
               2'b10: controls.aluOp = ALU_XOR;
               default: controls.aluOp = ALU_AND;
            endcase
         end
         default: begin
            // Unknown opcode keeps all writes and stores off
            illegal = 1'b1;
         end
      endcase
   end

endmodule

/* source/decode.sv */
`timescale 1ns/1ps

module decode (
   input  logic                        clk,
   input  logic                        reset,
   input  cpuPackage::word_t           instruction,
   input  cpuPackage::controlSignals_t controls,
   input  logic                        halted,
   input  cpuPackage::word_t           aluResult,
   input  cpuPackage::word_t           readData,
   input  cpuPackage::word_t           nextPc,
   output cpuPackage::word_t           read1Data,
   output cpuPackage::word_t           read2Data,
   output cpuPackage::word_t           immediate,
   output cpuPackage::commit_t         commit
);
   import cpuPackage::*;

   word_t regFile [8];
   regSel_t writeSel;
   word_t writeData;

   assign read1Data = regFile[instruction[10:8]];
   assign read2Data = regFile[instruction[7:5]];

   always_comb begin
      case (controls.immSel)
         IMM_S5:  immediate = {{11{instruction[4]}}, instruction[4:0]};
         IMM_Z5:  immediate = {11'b0, instruction[4:0]};
         IMM_S8:  immediate = {{8{instruction[7]}}, instruction[7:0]};
         default: immediate = {{5{instruction[10]}}, instruction[10:0]};
      endcase
   end

   always_comb begin
      case (controls.regDst)
         DST_RD:  writeSel = instruction[4:2];
         DST_IMM: writeSel = instruction[7:5];
         DST_RS:  writeSel = instruction[10:8];
         default: writeSel = LINK_REG;
      endcase
   end

   // Write-back source
   always_comb begin
      if (controls.link) begin
         writeData = nextPc;
      end else if (controls.memToReg) begin
         writeData = readData;
      end else begin
         writeData = aluResult;
      end
   end

   // Nothing commits while reset is held or once halted
   assign commit.valid = controls.regWrite && !halted && !reset;
   assign commit.sel = writeSel;
   assign commit.data = writeData;

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 8; i++) begin
            regFile[i] <= '0;
         end
      end else if (commit.valid) begin
         regFile[commit.sel] <= commit.data;
      end
   end

endmodule

/* source/execute.sv */
`timescale 1ns/1ps

module execute (
   input  cpuPackage::word_t           read1Data,
   input  cpuPackage::word_t           read2Data,
   input  cpuPackage::word_t           immediate,
   input  cpuPackage::controlSignals_t controls,
   output cpuPackage::word_t           aluResult,
   output logic                        branchTaken
);
   import cpuPackage::*;

   word_t operandB;
   logic isZero;

   // Immediate forms take the extended immediate
   assign operandB = controls.aluSrc ? immediate : read2Data;

   always_comb begin
      case (controls.aluOp)
         ALU_ADD: begin
            aluResult = read1Data + operandB;
         end
         ALU_SUB: begin
            aluResult = read1Data - operandB;
         end
         ALU_XOR: begin
            aluResult = read1Data ^ operandB;
         end
         ALU_AND: begin
            aluResult = read1Data & operandB;
         end
         ALU_PASSB: begin
            // LBI result is the immediate itself
            aluResult = operandB;
         end
         default: begin
            aluResult = '0;
         end
      endcase
   end

   // Branch on first source
   assign isZero = (read1Data == '0);

   always_comb begin
      branchTaken = (controls.branchZero && isZero) ||
                    (controls.branchNonZero && !isZero);
   end

endmodule

/* source/dataMemory.sv */
`timescale 1ns/1ps

module dataMemory (
   input  logic                        clk,
   input  cpuPackage::word_t           address,
   input  cpuPackage::word_t           writeData,
   input  cpuPackage::controlSignals_t controls,
   input  logic                        halted,
   output cpuPackage::word_t           readData
);
   import cpuPackage::*;

   word_t mem [DMEM_DEPTH];
   logic [7:0] wordIndex;

   // Word index from byte address
   assign wordIndex = address[8:1];

   always_ff @(posedge clk) begin
      if (controls.memWrite && !halted) begin
         mem[wordIndex] <= writeData;
      end
   end

   assign readData = controls.memRead ? mem[wordIndex] : '0;

endmodule

/* source/processor.sv */
`timescale 1ns/1ps

module processor (
   input  logic                      clk,
   input  logic                      reset,
   input  cpuPackage::programWrite_t programWrite,
   output cpuPackage::commit_t       commit,
   output logic                      halted,
   output logic                      err
);
   import cpuPackage::*;

   word_t instruction;
   word_t nextPc;
   word_t read1Data;
   word_t read2Data;
   word_t immediate;
   word_t aluResult;
   word_t readData;
   controlSignals_t controls;
   logic illegal;
   logic branchTaken;

   fetch fetch_i (
      .clk(clk),
      .reset(reset),
      .programWrite(programWrite),
      .controls(controls),
      .illegal(illegal),
      .branchTaken(branchTaken),
      .jumpTarget(aluResult),
      .immediate(immediate),
      .instruction(instruction),
      .nextPc(nextPc),
      .halted(halted),
      .err(err)
   );

   control control_i (
      .instruction(instruction),
      .controls(controls),
      .illegal(illegal)
   );

   decode decode_i (
      .clk(clk),
      .reset(reset),
      .instruction(instruction),
      .controls(controls),
      .halted(halted),
      .aluResult(aluResult),
      .readData(readData),
      .nextPc(nextPc),
      .read1Data(read1Data),
      .read2Data(read2Data),
      .immediate(immediate),
      .commit(commit)
   );

   execute execute_i (
      .read1Data(read1Data),
      .read2Data(read2Data),
      .immediate(immediate),
      .controls(controls),
      .aluResult(aluResult),
      .branchTaken(branchTaken)
   );

   // Store data comes from the second read port
   dataMemory dataMemory_i (
      .clk(clk),
      .address(aluResult),
      .writeData(read2Data),
      .controls(controls),
      .halted(halted),
      .readData(readData)
   );

endmodule

/* bench/processorBench.sv */
`timescale 1ns/1ps

module processorBench;
   import cpuPackage::*;

   // Six tests at up to 40 cycles each, plus margin
   localparam int CYCLE_LIMIT = 6 * 40 + 160;

   logic clk;
   logic reset;
   programWrite_t programWrite;
   commit_t commit;
   logic halted;
   logic err;

   int cycleCount = 0;
   int errors = 0;
   int testsRun = 0;
   int testsFailed = 0;

   word_t programWords[$];
   commit_t expectQ[$];
   word_t model[8];

   processor dut_i (
      .clk(clk),
      .reset(reset),
      .programWrite(programWrite),
      .commit(commit),
      .halted(halted),
      .err(err)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= CYCLE_LIMIT) begin
         $display("Timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   // Instruction encoders, fields as laid out in the instruction format
   function automatic word_t encodeImmediate(opcode_t op, regSel_t rs, regSel_t rd,
                                             logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic word_t encodeRegister(regSel_t rs, regSel_t rt, regSel_t rd,
                                            logic [1:0] ext);
      return {OP_RFORMAT, rs, rt, rd, ext};
   endfunction

   function automatic word_t encodeLbi(regSel_t rs, logic [7:0] imm);
      return {OP_LBI, rs, imm};
   endfunction

   function automatic word_t encodeBranch(opcode_t op, regSel_t rs, logic [7:0] offset);
      return {op, rs, offset};
   endfunction

   function automatic word_t encodeJump(opcode_t op, logic [10:0] offset);
      return {op, offset};
   endfunction

   function automatic word_t signExtend8(logic [7:0] value);
      return word_t'($signed(value));
   endfunction

   task automatic checkSel(regSel_t actual, regSel_t expected, string what);
      if (actual !== expected) begin
         errors++;
         $display("CHECK FAILED at time %0t: %s expected r%0d, got r%0d",
                  $time, what, expected, actual);
      end
   endtask

   task automatic checkWord(word_t actual, word_t expected, string what);
      if (actual !== expected) begin
         errors++;
         $display("CHECK FAILED at time %0t: %s expected 16'h%04h, got 16'h%04h",
                  $time, what, expected, actual);
      end
   endtask

   task automatic checkFlag(bit actual, bit expected, string what);
      if (actual !== expected) begin
         errors++;
         $display("CHECK FAILED at time %0t: %s expected %0b, got %0b",
                  $time, what, expected, actual);
      end
   endtask

   task automatic startProgram();
      programWords.delete();
      expectQ.delete();
      for (int i = 0; i < 8; i++) begin
         model[i] = '0;
      end
   endtask

   // Register model update plus the commit it should produce
   task automatic expectWrite(regSel_t sel, word_t data);
      commit_t entry;
      entry.valid = 1'b1;
      entry.sel = sel;
      entry.data = data;
      model[sel] = data;
      expectQ.push_back(entry);
   endtask

   // Program goes in one word per edge while reset is held
   task automatic loadProgram();
      @(posedge clk);
      reset <= 1'b1;
      for (int i = 0; i < programWords.size(); i++) begin
         @(posedge clk);
         programWrite <= '{enable: 1'b1, address: 8'(i), data: programWords[i]};
      end
      @(posedge clk);
      programWrite <= '0;
      // Reset state, with the program already in place
      @(negedge clk);
      checkFlag(commit.valid, 1'b0, "commit during reset");
      checkFlag(halted, 1'b0, "halted during reset");
      checkFlag(err, 1'b0, "err during reset");
      @(posedge clk);
      reset <= 1'b0;
   endtask

   task automatic runProgram(bit expectErr);
      commit_t expected;
      loadProgram();
      @(negedge clk);
      checkFlag(halted, 1'b0, "halted after reset");
      checkFlag(err, 1'b0, "err after reset");
      while (!halted) begin
         if (commit.valid) begin
            if (expectQ.size() == 0) begin
               errors++;
               $display("Unexpected register write to r%0d at time %0t", commit.sel, $time);
            end else begin
               expected = expectQ.pop_front();
               checkSel(commit.sel, expected.sel, "commit register");
               checkWord(commit.data, expected.data, "commit data");
            end
         end
         @(negedge clk);
      end
      // Core must stay quiet once stopped
      repeat (3) begin
         checkFlag(commit.valid, 1'b0, "commit while halted");
         @(negedge clk);
      end
      checkFlag(halted, 1'b1, "halted at end");
      checkFlag(err, expectErr, "err at end");
      if (expectQ.size() != 0) begin
         errors++;
         $display("%0d expected register writes never committed", expectQ.size());
      end
   endtask

   task automatic reportTest(string name, int errorsBefore);
      testsRun++;
      if (errors == errorsBefore) begin
         $display("%s: passed", name);
      end else begin
         testsFailed++;
         $display("%s: failed with %0d errors", name, errors - errorsBefore);
      end
   endtask

   task automatic testAlu();
      int errorsBefore;
      logic [7:0] a;
      logic [7:0] b;
      errorsBefore = errors;
      a = 8'($urandom());
      b = 8'($urandom());
      startProgram();
      programWords.push_back(encodeLbi(3'd1, a));
      programWords.push_back(encodeLbi(3'd2, b));
      programWords.push_back(encodeRegister(3'd1, 3'd2, 3'd3, 2'b00));
      programWords.push_back(encodeRegister(3'd1, 3'd2, 3'd4, 2'b01));
      programWords.push_back(encodeRegister(3'd1, 3'd2, 3'd5, 2'b10));
      programWords.push_back(encodeRegister(3'd1, 3'd2, 3'd6, 2'b11));
      programWords.push_back({OP_HALT, 11'd0});
      expectWrite(3'd1, signExtend8(a));
      expectWrite(3'd2, signExtend8(b));
      expectWrite(3'd3, model[1] + model[2]);
      expectWrite(3'd4, model[1] - model[2]);
      expectWrite(3'd5, model[1] ^ model[2]);
      expectWrite(3'd6, model[1] & model[2]);
      runProgram(1'b0);
      reportTest("register format ALU", errorsBefore);
   endtask

   task automatic testImmediates();
      int errorsBefore;
      logic [7:0] x;
      logic [4:0] imm;
      errorsBefore = errors;
      x = 8'($urandom());
      // Negative 5-bit immediate
      imm = {1'b1, 4'($urandom())};
      startProgram();
      programWords.push_back(encodeLbi(3'd1, x));
      programWords.push_back(encodeImmediate(OP_ADDI, 3'd1, 3'd2, imm));
      programWords.push_back(encodeImmediate(OP_SUBI, 3'd1, 3'd3, imm));
      programWords.push_back(encodeImmediate(OP_XORI, 3'd1, 3'd4, imm));
      programWords.push_back({OP_HALT, 11'd0});
      expectWrite(3'd1, signExtend8(x));
      expectWrite(3'd2, model[1] + word_t'($signed(imm)));
      expectWrite(3'd3, model[1] - word_t'($signed(imm)));
      expectWrite(3'd4, model[1] ^ {11'd0, imm});
      runProgram(1'b0);
      reportTest("immediate arithmetic", errorsBefore);
   endtask

   task automatic testMemory();
      int errorsBefore;
      logic [7:0] base;
      logic [7:0] valueA;
      logic [7:0] valueB;
      errorsBefore = errors;
      base = {1'b0, 6'($urandom()), 1'b0};
      valueA = 8'($urandom());
      valueB = valueA ^ 8'h5a;
      startProgram();
      programWords.push_back(encodeLbi(3'd1, base));
      programWords.push_back(encodeLbi(3'd2, valueA));
      programWords.push_back(encodeLbi(3'd3, valueB));
      programWords.push_back(encodeImmediate(OP_ST, 3'd1, 3'd2, 5'd0));
      programWords.push_back(encodeImmediate(OP_ST, 3'd1, 3'd3, 5'd4));
      programWords.push_back(encodeImmediate(OP_LD, 3'd1, 3'd4, 5'd0));
      programWords.push_back(encodeImmediate(OP_LD, 3'd1, 3'd5, 5'd4));
      programWords.push_back({OP_HALT, 11'd0});
      expectWrite(3'd1, signExtend8(base));
      expectWrite(3'd2, signExtend8(valueA));
      expectWrite(3'd3, signExtend8(valueB));
      // Each load sees only its own address
      expectWrite(3'd4, model[2]);
      expectWrite(3'd5, model[3]);
      runProgram(1'b0);
      reportTest("store and load", errorsBefore);
   endtask

   task automatic testBranches();
      int errorsBefore;
      logic [7:0] nonZero;
      errorsBefore = errors;
      nonZero = {1'b1, 7'($urandom())};
      startProgram();
      programWords.push_back(encodeLbi(3'd1, 8'h00));
      programWords.push_back(encodeLbi(3'd2, nonZero));
      // Taken, next 6 plus 2 lands on word 4
      programWords.push_back(encodeBranch(OP_BEQZ, 3'd1, 8'd2));
      programWords.push_back(encodeLbi(3'd3, 8'h11));
      programWords.push_back(encodeBranch(OP_BEQZ, 3'd2, 8'd2));
      programWords.push_back(encodeLbi(3'd4, 8'h22));
      // Taken, next 14 plus 2 lands on word 8
      programWords.push_back(encodeBranch(OP_BNEZ, 3'd2, 8'd2));
      programWords.push_back(encodeLbi(3'd5, 8'h33));
      programWords.push_back(encodeBranch(OP_BNEZ, 3'd1, 8'd2));
      programWords.push_back(encodeLbi(3'd6, 8'h44));
      programWords.push_back({OP_HALT, 11'd0});
      expectWrite(3'd1, 16'h0000);
      expectWrite(3'd2, signExtend8(nonZero));
      expectWrite(3'd4, 16'h0022);
      expectWrite(3'd6, 16'h0044);
      runProgram(1'b0);
      reportTest("conditional branches", errorsBefore);
   endtask

   task automatic testJumps();
      int errorsBefore;
      errorsBefore = errors;
      startProgram();
      programWords.push_back(encodeLbi(3'd1, 8'h01));
      // Link gets 4, target 4 plus 2 is word 3
      programWords.push_back(encodeJump(OP_JAL, 11'd2));
      programWords.push_back(encodeLbi(3'd2, 8'h55));
      // Next 8 plus 2 is word 5
      programWords.push_back(encodeJump(OP_J, 11'd2));
      programWords.push_back(encodeLbi(3'd3, 8'h66));
      programWords.push_back(encodeLbi(3'd4, 8'h77));
      programWords.push_back({OP_HALT, 11'd0});
      expectWrite(3'd1, 16'h0001);
      expectWrite(LINK_REG, 16'd4);
      expectWrite(3'd4, 16'h0077);
      runProgram(1'b0);
      reportTest("jump and link", errorsBefore);
   endtask

   task automatic testHaltAndIllegal();
      int errorsBefore;
      logic [7:0] x;
      errorsBefore = errors;
      x = 8'($urandom());
      startProgram();
      programWords.push_back(encodeLbi(3'd1, x));
      programWords.push_back({OP_HALT, 11'd0});
      programWords.push_back(encodeLbi(3'd2, 8'h12));
      expectWrite(3'd1, signExtend8(x));
      runProgram(1'b0);
      // Opcode 11111 is outside the subset
      startProgram();
      programWords.push_back(encodeLbi(3'd1, x));
      programWords.push_back({5'b11111, 11'd0});
      programWords.push_back(encodeLbi(3'd2, 8'h12));
      programWords.push_back({OP_HALT, 11'd0});
      expectWrite(3'd1, signExtend8(x));
      runProgram(1'b1);
      reportTest("halt and illegal opcode", errorsBefore);
   endtask

   initial begin
      reset = 1'b1;
      programWrite = '0;
      void'($urandom(32'he054_95a3));
      testAlu();
      testImmediates();
      testMemory();
      testBranches();
      testJumps();
      testHaltAndIllegal();
      $display("Tests run %0d, tests failed %0d, check errors %0d",
               testsRun, testsFailed, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* list.f */
source/cpuPackage.sv
source/fetch.sv
source/control.sv
source/decode.sv
source/execute.sv
source/dataMemory.sv
source/processor.sv
bench/processorBench.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module processorBench -f list.f -o simv
result="$(./obj_dir/simv)"
echo "$result"

if grep -q "SIMULATION PASSED" <<< "$result"; then
   exit 0
fi
exit 1
